//--- flist.f
+incdir+test
hdl/bp_pkg.sv
hdl/btb.sv
hdl/gshare_pht.sv
hdl/predict_lookup.sv
hdl/inflight_queue.sv
hdl/resolve_update.sv
hdl/bp_top.sv
test/bp_tb.sv

//--- Makefile
# Verilator build and run of the branch predictor testbench

VERILATOR  ?= verilator
TOP        ?= bp_tb
RTL_TOP    ?= bp_top
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing --assert
LINT_FLAGS ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- test/bp_ref_model.svh
// reference model of the target buffer, counter table, global history and pending predictions
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH
`default_nettype none

localparam int PHT_ENTRIES = 1 << HIST_BITS;

// what a prediction used, held until its resolve
typedef struct packed {
    logic [HIST_BITS-1:0] idx;
    logic                 taken;
    logic [XLEN-1:0]      target;
} pending_t;

logic            btb_valid  [BTB_ENTRIES];
logic [XLEN-1:0] btb_pc     [BTB_ENTRIES];
logic [XLEN-1:0] btb_target [BTB_ENTRIES];
br_kind_e        btb_kind   [BTB_ENTRIES];
int              ctr        [PHT_ENTRIES];
int              hist;
pending_t        pending    [$];

function automatic void reset_model();
    for (int i = 0; i < BTB_ENTRIES; i++) begin
        btb_valid[i]  = 1'b0;
        btb_pc[i]     = '0;
        btb_target[i] = '0;
        btb_kind[i]   = KIND_BRANCH;
    end
    for (int i = 0; i < PHT_ENTRIES; i++) begin
        ctr[i] = int'(CTR_RESET);
    end
    hist = 0;
    pending.delete();
endfunction

function automatic prediction_t lookup_prediction(input logic [XLEN-1:0] pc);
    prediction_t pred;
    pending_t    entry;
    int          bi;
    int          pi;
    logic        hit;
    bi  = int'(pc[XLEN-1:2]) % BTB_ENTRIES;
    pi  = (int'(pc[XLEN-1:2]) % PHT_ENTRIES) ^ hist;
    // index and tag together cover every pc bit above the byte offset
    hit = btb_valid[bi] && (btb_pc[bi][XLEN-1:2] == pc[XLEN-1:2]);
    pred = '0;
    if (hit && (btb_kind[bi] == KIND_JUMP || ctr[pi] >= 2)) begin
        pred.taken  = 1'b1;
        pred.target = btb_target[bi];
    end
    entry.idx    = HIST_BITS'(pi);
    entry.taken  = pred.taken;
    entry.target = pred.target;
    pending.push_back(entry);
    return pred;
endfunction

// trains the model and returns whether the oldest prediction was wrong
function automatic logic resolve_outcome(input resolve_t res);
    pending_t head;
    int       bi;
    int       ci;
    head = pending.pop_front();
    if (res.kind == KIND_BRANCH) begin
        ci = int'(head.idx);
        if (res.taken && ctr[ci] < 3) begin
            ctr[ci] = ctr[ci] + 1;
        end else if (!res.taken && ctr[ci] > 0) begin
            ctr[ci] = ctr[ci] - 1;
        end
        hist = ((hist << 1) | int'(res.taken)) % PHT_ENTRIES;
    end
    if (res.taken) begin
        bi = int'(res.pc[XLEN-1:2]) % BTB_ENTRIES;
        btb_valid[bi]  = 1'b1;
        btb_pc[bi]     = res.pc;
        btb_target[bi] = res.target;
        btb_kind[bi]   = res.kind;
    end
    return (head.taken != res.taken) || (res.taken && head.target != res.target);
endfunction

`default_nettype wire
`endif

//--- test/bp_tb.sv
// testbench module with clock, reset, random fetch and resolve traffic, model checks and timeout
`default_nettype none

module bp_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import bp_pkg::*;

    localparam int BTB_ENTRIES    = 32;
    localparam int QUEUE_DEPTH    = 4;
    localparam int POOL_SIZE      = 12;
    localparam int NUM_OPS        = 2000;
    // ten cycles per operation is far above the slowest fetch and resolve pattern
    localparam int TIMEOUT_CYCLES = NUM_OPS * 10;
    localparam logic [31:0] SEED  = 32'h8322_b260;

    logic        clk;
    logic        rst_n_i;
    logic        fetch_valid_i;
    fetch_req_t  fetch_i;
    logic        resolve_valid_i;
    resolve_t    resolve_i;
    logic        pred_valid_o;
    prediction_t pred_o;
    logic        mispredict_o;

    `include "bp_ref_model.svh"

    logic [XLEN-1:0] pool_pc     [POOL_SIZE];
    logic [XLEN-1:0] pool_target [POOL_SIZE];
    br_kind_e        pool_kind   [POOL_SIZE];
    int              pool_bias   [POOL_SIZE];

    // resolves waiting for their cycle with the oldest first
    resolve_t        sched_res [$];
    int              sched_due [$];

    logic            exp_pred_valid;
    prediction_t     exp_pred;
    logic            exp_mispredict;
    int              cycle;
    int              fetched;
    int              taken_preds;
    int              mispredicts;
    int              same_cycle_pairs;
    int              timeout_cnt = 0;

    bp_top #(
        .BTB_ENTRIES (BTB_ENTRIES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) bp_top_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .fetch_valid_i   (fetch_valid_i),
        .fetch_i         (fetch_i),
        .resolve_valid_i (resolve_valid_i),
        .resolve_i       (resolve_i),
        .pred_valid_o    (pred_valid_o),
        .pred_o          (pred_o),
        .mispredict_o    (mispredict_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        timeout_cnt <= timeout_cnt + 1;
        if (timeout_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "run stopped by timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got 0x%08h expected 0x%08h in cycle %0d",
                     name, got, exp, cycle);
            $display("Simulation failed");
            $fatal(1, "run stopped at first error");
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            $display("Simulation failed");
            $fatal(1, "run stopped at first error");
        end
    endtask

    task automatic check_outputs();
        check_value("pred_valid_o", 32'(pred_valid_o), 32'(exp_pred_valid));
        if (exp_pred_valid) begin
            check_value("pred_o.taken", 32'(pred_o.taken), 32'(exp_pred.taken));
            check_value("pred_o.target", pred_o.target, exp_pred.target);
        end
        check_value("mispredict_o", 32'(mispredict_o), 32'(exp_mispredict));
    endtask

    // the model looks up before it resolves since the dut reads the old table state
    task automatic drive_cycle();
        int       k;
        int       due;
        resolve_t res;
        fetch_valid_i   = 1'b0;
        resolve_valid_i = 1'b0;
        exp_pred_valid  = 1'b0;
        exp_mispredict  = 1'b0;
        if (fetched < NUM_OPS && sched_res.size() < QUEUE_DEPTH && ($urandom % 4) != 0) begin
            k              = int'($urandom % POOL_SIZE);
            fetch_valid_i  = 1'b1;
            fetch_i.pc     = pool_pc[k];
            exp_pred_valid = 1'b1;
            exp_pred       = lookup_prediction(pool_pc[k]);
            if (exp_pred.taken) begin
                taken_preds++;
            end
            res.pc     = pool_pc[k];
            res.target = pool_target[k];
            res.kind   = pool_kind[k];
            if (pool_kind[k] == KIND_JUMP) begin
                res.taken = 1'b1;
            end else begin
                res.taken = int'($urandom % 100) < pool_bias[k];
            end
            // keep resolves in order with at most one per cycle
            due = cycle + int'($urandom % 4);
            if (sched_due.size() != 0 && due <= sched_due[$]) begin
                due = sched_due[$] + 1;
            end
            sched_res.push_back(res);
            sched_due.push_back(due);
            fetched++;
        end
        if (sched_due.size() != 0 && sched_due[0] <= cycle) begin
            res = sched_res.pop_front();
            sched_due.delete(0);
            resolve_valid_i = 1'b1;
            resolve_i       = res;
            exp_mispredict  = resolve_outcome(res);
            if (exp_mispredict) begin
                mispredicts++;
            end
            // an older instance of the fetched pc trains the tables in this cycle
            if (fetch_valid_i && fetch_i.pc == res.pc && sched_res.size() != 0) begin
                same_cycle_pairs++;
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk              = 1'b0;
        rst_n_i          = 1'b0;
        fetch_valid_i    = 1'b0;
        fetch_i          = '0;
        resolve_valid_i  = 1'b0;
        resolve_i        = '0;
        exp_pred_valid   = 1'b0;
        exp_pred         = '0;
        exp_mispredict   = 1'b0;
        cycle            = 0;
        fetched          = 0;
        taken_preds      = 0;
        mispredicts      = 0;
        same_cycle_pairs = 0;
        // pc i and i+6 share a btb slot with different tags
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool_pc[i]     = 32'h0000_8000 + 32'(i % 6) * 32'd8 + 32'(i / 6) * 32'h1000;
            pool_target[i] = ($urandom & 32'h0003_fffc) | 32'h0004_0000;
            pool_kind[i]   = (i % 3 == 0) ? KIND_JUMP : KIND_BRANCH;
            pool_bias[i]   = int'($urandom % 101);
        end
        reset_model();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        check_outputs();
        while (fetched < NUM_OPS || sched_res.size() != 0) begin
            drive_cycle();
            @(negedge clk);
            check_outputs();
            cycle++;
        end
        expect_true(taken_preds > 0, "no fetch was ever predicted taken");
        expect_true(mispredicts > 0, "no resolve was ever mispredicted");
        expect_true(same_cycle_pairs > 0,
                    "no fetch met an older resolve of the same pc in one cycle");
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/bp_top.sv
// bp_top: branch predictor top level connecting btb, gshare table, lookup, queue and update
`default_nettype none

module bp_top #(
    parameter int BTB_ENTRIES = 32,
    parameter int QUEUE_DEPTH = 4
) (
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    input  wire logic                fetch_valid_i,
    input  wire bp_pkg::fetch_req_t  fetch_i,
    input  wire logic                resolve_valid_i,
    input  wire bp_pkg::resolve_t    resolve_i,
    output logic                     pred_valid_o,
    output bp_pkg::prediction_t      pred_o,
    output logic                     mispredict_o
);

    import bp_pkg::*;

    // lookup side
    logic [XLEN-1:0]      rd_pc;
    logic                 btb_hit;
    logic [XLEN-1:0]      btb_target;
    br_kind_e             btb_kind;
    logic [HIST_BITS-1:0] pht_idx;
    logic                 pht_taken;

    // queue traffic
    logic                 push;
    inflight_t            push_data;
    logic                 pop;
    inflight_t            head;

    // training side
    logic                 btb_wr_valid;
    btb_wr_t              btb_wr;
    logic                 pht_wr_valid;
    pht_wr_t              pht_wr;

    btb #(
        .ENTRIES (BTB_ENTRIES)
    ) btb_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_pc_i    (rd_pc),
        .hit_o      (btb_hit),
        .target_o   (btb_target),
        .kind_o     (btb_kind),
        .wr_valid_i (btb_wr_valid),
        .wr_i       (btb_wr)
    );

    gshare_pht gshare_pht_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_pc_i    (rd_pc),
        .rd_idx_o   (pht_idx),
        .rd_taken_o (pht_taken),
        .wr_valid_i (pht_wr_valid),
        .wr_i       (pht_wr)
    );

    predict_lookup predict_lookup_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_i       (fetch_i),
        .btb_hit_i     (btb_hit),
        .btb_target_i  (btb_target),
        .btb_kind_i    (btb_kind),
        .pht_idx_i     (pht_idx),
        .pht_taken_i   (pht_taken),
        .rd_pc_o       (rd_pc),
        .pred_valid_o  (pred_valid_o),
        .pred_o        (pred_o),
        .push_o        (push),
        .push_data_o   (push_data)
    );

    inflight_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) inflight_queue_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .pop_data_o  (head)
    );

    resolve_update resolve_update_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .resolve_valid_i (resolve_valid_i),
        .resolve_i       (resolve_i),
        .head_i          (head),
        .pop_o           (pop),
        .btb_wr_valid_o  (btb_wr_valid),
        .btb_wr_o        (btb_wr),
        .pht_wr_valid_o  (pht_wr_valid),
        .pht_wr_o        (pht_wr),
        .mispredict_o    (mispredict_o)
    );

endmodule

`default_nettype wire

//--- hdl/resolve_update.sv
// resolve_update: consumer popping the oldest prediction, training tables, flagging mispredicts
`default_nettype none

module resolve_update (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               resolve_valid_i,
    input  wire bp_pkg::resolve_t   resolve_i,
    input  wire bp_pkg::inflight_t  head_i,
    output logic                    pop_o,
    output logic                    btb_wr_valid_o,
    output bp_pkg::btb_wr_t         btb_wr_o,
    output logic                    pht_wr_valid_o,
    output bp_pkg::pht_wr_t         pht_wr_o,
    output logic                    mispredict_o
);

    import bp_pkg::*;

    logic is_branch;
    logic dir_wrong;
    logic target_wrong;
    logic mispredict_d;
    logic mispredict_q;

    // resolves come in fetch order, so the head is always this branch
    assign pop_o = resolve_valid_i;

    assign is_branch = (resolve_i.kind == KIND_BRANCH);

    assign dir_wrong    = (head_i.pred_taken != resolve_i.taken);
    assign target_wrong = resolve_i.taken && (head_i.pred_target != resolve_i.target);
    assign mispredict_d = dir_wrong || target_wrong;

    // only taken transfers are worth a btb slot
    assign btb_wr_valid_o  = resolve_valid_i && resolve_i.taken;
    assign btb_wr_o.pc     = resolve_i.pc;
    assign btb_wr_o.target = resolve_i.target;
    assign btb_wr_o.kind   = resolve_i.kind;

    // train the counter that made the prediction, not the one the pc maps to now
    assign pht_wr_valid_o = resolve_valid_i && is_branch;
    assign pht_wr_o.idx   = head_i.pht_idx;
    assign pht_wr_o.inc   = resolve_i.taken;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mispredict_q <= 1'b0;
        end else begin
            mispredict_q <= resolve_valid_i && mispredict_d;
        end
    end

    assign mispredict_o = mispredict_q;

endmodule

`default_nettype wire

//--- hdl/inflight_queue.sv
// inflight_queue: circular FIFO of in-flight predictions with a combinational head
`default_nettype none

module inflight_queue #(
    parameter int DEPTH = 4
) (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               push_i,
    input  wire bp_pkg::inflight_t  push_data_i,
    input  wire logic               pop_i,
    output bp_pkg::inflight_t       pop_data_o
);

    import bp_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    inflight_t          mem_q [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [PTR_W:0]     count_q;
    logic               empty;

    assign empty = (count_q == '0);

    // an empty queue hands the incoming entry straight to a same-cycle pop
    assign pop_data_o = empty ? push_data_i : mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (!push_i && pop_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/predict_lookup.sv
// predict_lookup: producer forming the registered prediction and the in-flight entry
`default_nettype none

module predict_lookup (
    input  wire logic                         clk,
    input  wire logic                         rst_n_i,
    input  wire logic                         fetch_valid_i,
    input  wire bp_pkg::fetch_req_t           fetch_i,
    input  wire logic                         btb_hit_i,
    input  wire logic [bp_pkg::XLEN-1:0]      btb_target_i,
    input  wire bp_pkg::br_kind_e             btb_kind_i,
    input  wire logic [bp_pkg::HIST_BITS-1:0] pht_idx_i,
    input  wire logic                         pht_taken_i,
    output logic [bp_pkg::XLEN-1:0]           rd_pc_o,
    output logic                              pred_valid_o,
    output bp_pkg::prediction_t               pred_o,
    output logic                              push_o,
    output bp_pkg::inflight_t                 push_data_o
);

    import bp_pkg::*;

    prediction_t pred_d;
    prediction_t pred_q;
    logic        pred_valid_q;

    assign rd_pc_o = fetch_i.pc;

    // jump hit is always taken, branch hit follows the counter, miss falls through
    always_comb begin
        pred_d = '0;
        if (btb_hit_i) begin
            if (btb_kind_i == KIND_JUMP) begin
                pred_d.taken = 1'b1;
            end else begin
                pred_d.taken = pht_taken_i;
            end
        end
        if (pred_d.taken) begin
            pred_d.target = btb_target_i;
        end
    end

    // entry enters the queue on the same edge that registers the prediction
    assign push_o                  = fetch_valid_i;
    assign push_data_o.pht_idx     = pht_idx_i;
    assign push_data_o.pred_taken  = pred_d.taken;
    assign push_data_o.pred_target = pred_d.target;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pred_valid_q <= 1'b0;
            pred_q       <= '0;
        end else begin
            pred_valid_q <= fetch_valid_i;
            if (fetch_valid_i) begin
                pred_q <= pred_d;
            end
        end
    end

    assign pred_valid_o = pred_valid_q;
    assign pred_o       = pred_q;

endmodule

`default_nettype wire

//--- hdl/gshare_pht.sv
// gshare_pht: 2-bit counter table and global history, xor indexed read, saturating update
`default_nettype none

module gshare_pht (
    input  wire logic                         clk,
    input  wire logic                         rst_n_i,
    input  wire logic [bp_pkg::XLEN-1:0]      rd_pc_i,
    output logic [bp_pkg::HIST_BITS-1:0]      rd_idx_o,
    output logic                              rd_taken_o,
    input  wire logic                         wr_valid_i,
    input  wire bp_pkg::pht_wr_t              wr_i
);

    import bp_pkg::*;

    localparam int PHT_ENTRIES = 1 << HIST_BITS;

    logic [1:0]           ctr_q [PHT_ENTRIES];
    logic [HIST_BITS-1:0] hist_q;

    logic [HIST_BITS-1:0] rd_idx;
    logic [1:0]           wr_ctr;
    logic [1:0]           wr_ctr_next;

    // pc bits above the byte offset, hashed with the history
    assign rd_idx     = rd_pc_i[HIST_BITS+1:2] ^ hist_q;
    assign rd_idx_o   = rd_idx;
    assign rd_taken_o = ctr_q[rd_idx][1];

    assign wr_ctr = ctr_q[wr_i.idx];

    always_comb begin
        wr_ctr_next = wr_ctr;
        if (wr_i.inc) begin
            if (wr_ctr != 2'b11) begin
                wr_ctr_next = wr_ctr + 2'd1;
            end
        end else begin
            if (wr_ctr != 2'b00) begin
                wr_ctr_next = wr_ctr - 2'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                ctr_q[i] <= CTR_RESET;
            end
            hist_q <= '0;
        end else if (wr_valid_i) begin
            ctr_q[wr_i.idx] <= wr_ctr_next;
            // newest outcome enters at bit 0
            hist_q <= {hist_q[HIST_BITS-2:0], wr_i.inc};
        end
    end

endmodule

`default_nettype wire

//--- hdl/btb.sv
// btb: tagged direct-mapped branch target buffer, combinational read and one write port
`default_nettype none

module btb #(
    parameter int ENTRIES = 32
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n_i,
    input  wire logic [bp_pkg::XLEN-1:0]  rd_pc_i,
    output logic                          hit_o,
    output logic [bp_pkg::XLEN-1:0]       target_o,
    output bp_pkg::br_kind_e              kind_o,
    input  wire logic                     wr_valid_i,
    input  wire bp_pkg::btb_wr_t          wr_i
);

    import bp_pkg::*;

    localparam int IDX_BITS = $clog2(ENTRIES);
    // pc bits above the index, the low two bits are always zero
    localparam int TAG_BITS = XLEN - IDX_BITS - 2;

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [XLEN-1:0]     target;
        br_kind_e            kind;
    } btb_entry_t;

    btb_entry_t          entry_q [ENTRIES];
    logic [ENTRIES-1:0]  valid_q;

    logic [IDX_BITS-1:0] rd_idx;
    logic [TAG_BITS-1:0] rd_tag;
    btb_entry_t          rd_entry;
    logic [IDX_BITS-1:0] wr_idx;
    btb_entry_t          wr_entry;

    assign rd_idx   = rd_pc_i[IDX_BITS+1:2];
    assign rd_tag   = rd_pc_i[XLEN-1:IDX_BITS+2];
    assign rd_entry = entry_q[rd_idx];

    assign hit_o    = valid_q[rd_idx] && (rd_entry.tag == rd_tag);
    assign target_o = rd_entry.target;
    assign kind_o   = rd_entry.kind;

    assign wr_idx          = wr_i.pc[IDX_BITS+1:2];
    assign wr_entry.tag    = wr_i.pc[XLEN-1:IDX_BITS+2];
    assign wr_entry.target = wr_i.target;
    assign wr_entry.kind   = wr_i.kind;

    // a write replaces whatever the slot held, aliasing pcs simply evict each other
    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            entry_q[wr_idx] <= wr_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_valid_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/bp_pkg.sv
// predictor constants, branch kind enum and packed request, prediction, resolve and update structs
`default_nettype none

package bp_pkg;

    localparam int XLEN = 32;
    // history length, also the counter table index width
    localparam int HIST_BITS = 5;
    // weakly not taken
    localparam logic [1:0] CTR_RESET = 2'b01;

    typedef enum logic {
        KIND_BRANCH = 1'b0,
        KIND_JUMP   = 1'b1
    } br_kind_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
    } fetch_req_t;

    // target is zero whenever taken is low
    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } prediction_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic            taken;
        logic [XLEN-1:0] target;
        br_kind_e        kind;
    } resolve_t;

    // what a prediction used, kept until its branch resolves
    typedef struct packed {
        logic [HIST_BITS-1:0] pht_idx;
        logic                 pred_taken;
        logic [XLEN-1:0]      pred_target;
    } inflight_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
        br_kind_e        kind;
    } btb_wr_t;

    // inc is also the outcome bit shifted into the history
    typedef struct packed {
        logic [HIST_BITS-1:0] idx;
        logic                 inc;
    } pht_wr_t;

endpackage

`default_nettype wire
